/* tb.f */
bp_pkg.sv
local_hist_predictor.sv
gshare_predictor.sv
tournament_chooser.sv
predictor_config.sv
branch_predictor_top.sv
tb_branch_predictor.sv

/* tb_branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

    // Well above the roughly 700 cycles the directed tests need
    localparam int MAX_CYCLES = 5000;

    logic                                clk;
    logic                                rst;
    logic [bp_pkg::PC_W-1:0]             br_pc;
    logic                                commit_update;
    logic [bp_pkg::BHT_IDX_W-1:0]        commit_bht_idx;
    logic [bp_pkg::PHT_IDX_W-1:0]        commit_local_idx;
    logic [bp_pkg::PHT_IDX_W-1:0]        commit_global_idx;
    logic [bp_pkg::CHOICE_IDX_W-1:0]     commit_choice_idx;
    logic                                commit_local_taken;
    logic                                commit_global_taken;
    logic                                commit_pred_taken;
    logic                                commit_taken;
    logic                                cfg_write;
    bp_pkg::cfg_reg_e                    cfg_addr;
    logic [bp_pkg::CFG_DATA_W-1:0]       cfg_wdata;
    logic                                pred_taken;
    logic                                pred_local_taken;
    logic                                pred_global_taken;
    logic [bp_pkg::BHT_IDX_W-1:0]        pred_bht_idx;
    logic [bp_pkg::PHT_IDX_W-1:0]        pred_local_idx;
    logic [bp_pkg::PHT_IDX_W-1:0]        pred_global_idx;
    logic [bp_pkg::CHOICE_IDX_W-1:0]     pred_choice_idx;
    logic [bp_pkg::PC_W-1:0]             br_pc_out;
    logic [bp_pkg::CFG_DATA_W-1:0]       cfg_rdata;

    // Reference model of all predictor state
    logic [bp_pkg::BHR_LEN-1:0]  m_bht    [bp_pkg::BHT_ENTRIES];
    logic [1:0]                  m_lpht   [bp_pkg::PHT_ENTRIES];
    logic [1:0]                  m_gpht   [bp_pkg::PHT_ENTRIES];
    logic [1:0]                  m_choice [bp_pkg::CHOICE_ENTRIES];
    logic [bp_pkg::GHR_LEN-1:0]  m_ghr;
    bp_pkg::pred_mode_e          m_mode;
    int                          m_commits;
    int                          m_mispredicts;

    // Prediction info from the last lookup, returned at commit
    logic                                got_taken;
    logic                                got_local;
    logic                                got_global;
    logic [bp_pkg::BHT_IDX_W-1:0]        got_bht_idx;
    logic [bp_pkg::PHT_IDX_W-1:0]        got_local_idx;
    logic [bp_pkg::PHT_IDX_W-1:0]        got_global_idx;
    logic [bp_pkg::CHOICE_IDX_W-1:0]     got_choice_idx;

    int     errors = 0;
    int     cycles = 0;
    int     disagree_commits;
    int     agree_commits;
    integer seed;

    branch_predictor_top branch_predictor_top_inst (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual 0x%0h expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        $display("%-16s finished with %0d errors", name, errors - start);
    endtask

    // Saturating two-bit step, clamped to 0..3
    function automatic logic [1:0] next_counter(input logic [1:0] c, input logic up);
        int n;
        n = int'(c) + (up ? 1 : -1);
        if (n > 3) begin
            n = 3;
        end
        if (n < 0) begin
            n = 0;
        end
        return n[1:0];
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic write_reg(input bp_pkg::cfg_reg_e addr, input logic [31:0] data);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_write <= 1'b0;
        cfg_wdata <= '0;
    endtask

    task automatic read_reg(input bp_pkg::cfg_reg_e addr, output logic [31:0] data);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        data = cfg_rdata;
    endtask

    task automatic set_mode(input bp_pkg::pred_mode_e m);
        logic [31:0] rd;
        write_reg(bp_pkg::REG_MODE, {30'd0, m});
        m_mode = m;
        read_reg(bp_pkg::REG_MODE, rd);
        check_value("cfg_rdata REG_MODE", rd, {30'd0, m});
    endtask

    // One lookup, checked against the model once the outputs settle
    task automatic lookup(input logic [31:0] pc);
        logic [bp_pkg::PHT_IDX_W-1:0] exp_local_idx;
        logic [bp_pkg::PHT_IDX_W-1:0] exp_global_idx;
        logic                         exp_local;
        logic                         exp_global;
        logic                         exp_pred;
        @(posedge clk);
        br_pc <= pc;
        @(posedge clk);
        @(negedge clk);
        exp_local_idx  = m_bht[pc[9:2]] ^ pc[11:2];
        exp_global_idx = m_ghr ^ pc[11:2];
        exp_local      = m_lpht[exp_local_idx][1];
        exp_global     = m_gpht[exp_global_idx][1];
        case (m_mode)
            bp_pkg::MODE_STATIC_NT: exp_pred = 1'b0;
            bp_pkg::MODE_LOCAL:     exp_pred = exp_local;
            bp_pkg::MODE_GLOBAL:    exp_pred = exp_global;
            default:                exp_pred = m_choice[pc[9:2]][1] ? exp_global : exp_local;
        endcase
        check_value("br_pc_out", br_pc_out, pc);
        check_value("pred_bht_idx", pred_bht_idx, pc[9:2]);
        check_value("pred_choice_idx", pred_choice_idx, pc[9:2]);
        check_value("pred_local_idx", pred_local_idx, exp_local_idx);
        check_value("pred_global_idx", pred_global_idx, exp_global_idx);
        check_value("pred_local_taken", pred_local_taken, exp_local);
        check_value("pred_global_taken", pred_global_taken, exp_global);
        check_value("pred_taken", pred_taken, exp_pred);
        got_taken      = pred_taken;
        got_local      = pred_local_taken;
        got_global     = pred_global_taken;
        got_bht_idx    = pred_bht_idx;
        got_local_idx  = pred_local_idx;
        got_global_idx = pred_global_idx;
        got_choice_idx = pred_choice_idx;
    endtask

    // Return the last prediction info with the real outcome
    task automatic commit(input logic taken);
        @(posedge clk);
        commit_update       <= 1'b1;
        commit_bht_idx      <= got_bht_idx;
        commit_local_idx    <= got_local_idx;
        commit_global_idx   <= got_global_idx;
        commit_choice_idx   <= got_choice_idx;
        commit_local_taken  <= got_local;
        commit_global_taken <= got_global;
        commit_pred_taken   <= got_taken;
        commit_taken        <= taken;
        @(posedge clk);
        commit_update <= 1'b0;
        m_lpht[got_local_idx]  = next_counter(m_lpht[got_local_idx], taken);
        m_gpht[got_global_idx] = next_counter(m_gpht[got_global_idx], taken);
        m_bht[got_bht_idx]     = {m_bht[got_bht_idx][bp_pkg::BHR_LEN-2:0], taken};
        m_ghr                  = {m_ghr[bp_pkg::GHR_LEN-2:0], taken};
        if (got_local != got_global) begin
            m_choice[got_choice_idx] = next_counter(m_choice[got_choice_idx],
                                                    got_global == taken);
            disagree_commits++;
        end else begin
            agree_commits++;
        end
        m_commits++;
        if (got_taken != taken) begin
            m_mispredicts++;
        end
    endtask

    task automatic test_reset_state();
        int          start;
        logic [31:0] rd;
        start = errors;
        @(negedge clk);
        check_value("pred_taken", pred_taken, 0);
        check_value("pred_local_taken", pred_local_taken, 0);
        check_value("pred_global_taken", pred_global_taken, 0);
        read_reg(bp_pkg::REG_MODE, rd);
        check_value("cfg_rdata REG_MODE", rd, bp_pkg::MODE_TOURNAMENT);
        read_reg(bp_pkg::REG_COMMITS, rd);
        check_value("cfg_rdata REG_COMMITS", rd, 0);
        read_reg(bp_pkg::REG_MISPREDICTS, rd);
        check_value("cfg_rdata REG_MISPREDICTS", rd, 0);
        lookup(32'h0000_0F04);
        lookup(32'h8000_1230);
        report_test("reset_state", start);
    endtask

    task automatic test_local_loop();
        int          start;
        logic [31:0] pc;
        start = errors;
        pc = 32'h0000_1A3C;
        set_mode(bp_pkg::MODE_LOCAL);
        // Ten taken commits fill the history with ones, then the index holds still
        for (int i = 1; i <= 13; i++) begin
            lookup(pc);
            if (i >= 11) begin
                check_value("pred_local_idx", got_local_idx, 10'h3FF ^ pc[11:2]);
                check_value("pred_taken", got_taken, i == 13);
            end
            commit(1'b1);
        end
        // Taken, taken, not taken
        for (int i = 0; i < 30; i++) begin
            lookup(pc);
            commit((i % 3) != 2);
        end
        report_test("local_loop", start);
    endtask

    task automatic test_global_random();
        int          start;
        logic [31:0] pc;
        start = errors;
        set_mode(bp_pkg::MODE_GLOBAL);
        for (int i = 0; i < 40; i++) begin
            lookup(rand_pc());
            commit(rand_bit());
        end
        // Always taken, so the GHR fills with ones and one counter saturates
        pc = 32'h0000_2468;
        for (int i = 0; i < 16; i++) begin
            lookup(pc);
            if (i >= 12) begin
                check_value("pred_taken", got_taken, 1'b1);
            end
            commit(1'b1);
        end
        report_test("global_random", start);
    endtask

    task automatic test_tournament();
        int          start;
        int          global_picks;
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        start            = errors;
        global_picks     = 0;
        disagree_commits = 0;
        agree_commits    = 0;
        pc_a             = 32'h0000_3010;
        pc_b             = 32'h0000_3024;
        set_mode(bp_pkg::MODE_TOURNAMENT);
        // One branch always taken and one never taken, interleaved
        // Gshare settles on a taken counter before the local history fills
        for (int i = 0; i < 20; i++) begin
            lookup(pc_a);
            if (got_local != got_global && got_taken == got_global) begin
                global_picks++;
            end
            commit(1'b1);
            lookup(pc_b);
            commit(1'b0);
        end
        if (disagree_commits == 0 || agree_commits == 0) begin
            $display("Tournament test did not see both agreeing and disagreeing components");
            errors++;
        end
        if (global_picks == 0) begin
            $display("Tournament test never selected gshare when the components disagreed");
            errors++;
        end
        report_test("tournament", start);
    endtask

    task automatic test_static_not_taken();
        int          start;
        logic [31:0] pc;
        start = errors;
        pc    = 32'h0000_5B70;
        set_mode(bp_pkg::MODE_STATIC_NT);
        // Always taken, so both components learn taken while the output stays low
        for (int i = 0; i < 16; i++) begin
            lookup(pc);
            check_value("pred_taken", got_taken, 0);
            if (i >= 12) begin
                check_value("pred_local_taken", got_local, 1'b1);
                check_value("pred_global_taken", got_global, 1'b1);
            end
            commit(1'b1);
        end
        report_test("static_nt", start);
    endtask

    task automatic test_statistics();
        int          start;
        logic [31:0] rd;
        start = errors;
        set_mode(bp_pkg::MODE_TOURNAMENT);
        for (int i = 0; i < 8; i++) begin
            lookup(rand_pc());
            commit(rand_bit());
        end
        read_reg(bp_pkg::REG_COMMITS, rd);
        check_value("cfg_rdata REG_COMMITS", rd, m_commits);
        read_reg(bp_pkg::REG_MISPREDICTS, rd);
        check_value("cfg_rdata REG_MISPREDICTS", rd, m_mispredicts);
        // Counter addresses are read only
        write_reg(bp_pkg::REG_COMMITS, 32'hDEAD_BEEF);
        write_reg(bp_pkg::REG_MISPREDICTS, 32'h1234_5678);
        read_reg(bp_pkg::REG_COMMITS, rd);
        check_value("cfg_rdata REG_COMMITS", rd, m_commits);
        read_reg(bp_pkg::REG_MISPREDICTS, rd);
        check_value("cfg_rdata REG_MISPREDICTS", rd, m_mispredicts);
        write_reg(bp_pkg::REG_CLEAR, 32'h0);
        m_commits     = 0;
        m_mispredicts = 0;
        read_reg(bp_pkg::REG_COMMITS, rd);
        check_value("cfg_rdata REG_COMMITS", rd, 0);
        read_reg(bp_pkg::REG_MISPREDICTS, rd);
        check_value("cfg_rdata REG_MISPREDICTS", rd, 0);
        report_test("statistics", start);
    endtask

    initial begin
        seed = 33973;
        for (int i = 0; i < bp_pkg::PHT_ENTRIES; i++) begin
            m_lpht[i] = 2'b00;
            m_gpht[i] = 2'b00;
        end
        for (int i = 0; i < bp_pkg::BHT_ENTRIES; i++) begin
            m_bht[i]    = '0;
            m_choice[i] = 2'b00;
        end
        m_ghr         = '0;
        m_mode        = bp_pkg::MODE_TOURNAMENT;
        m_commits     = 0;
        m_mispredicts = 0;
        clk                 = 1'b0;
        rst                 = 1'b1;
        br_pc               = '0;
        commit_update       = 1'b0;
        commit_bht_idx      = '0;
        commit_local_idx    = '0;
        commit_global_idx   = '0;
        commit_choice_idx   = '0;
        commit_local_taken  = 1'b0;
        commit_global_taken = 1'b0;
        commit_pred_taken   = 1'b0;
        commit_taken        = 1'b0;
        cfg_write           = 1'b0;
        cfg_addr            = bp_pkg::REG_MODE;
        cfg_wdata           = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_local_loop();
        test_global_random();
        test_tournament();
        test_static_not_taken();
        test_statistics();
        $display("Summary: 6 tests run, %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* branch_predictor_top.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_top (
    input  wire                              clk,
    input  wire                              rst,
    input  wire [bp_pkg::PC_W-1:0]           br_pc,
    input  wire                              commit_update,
    input  wire [bp_pkg::BHT_IDX_W-1:0]      commit_bht_idx,
    input  wire [bp_pkg::PHT_IDX_W-1:0]      commit_local_idx,
    input  wire [bp_pkg::PHT_IDX_W-1:0]      commit_global_idx,
    input  wire [bp_pkg::CHOICE_IDX_W-1:0]   commit_choice_idx,
    input  wire                              commit_local_taken,
    input  wire                              commit_global_taken,
    input  wire                              commit_pred_taken,
    input  wire                              commit_taken,
    input  wire                              cfg_write,
    input  wire bp_pkg::cfg_reg_e            cfg_addr,
    input  wire [bp_pkg::CFG_DATA_W-1:0]     cfg_wdata,
    output logic                             pred_taken,
    output logic                             pred_local_taken,
    output logic                             pred_global_taken,
    output logic [bp_pkg::BHT_IDX_W-1:0]     pred_bht_idx,
    output logic [bp_pkg::PHT_IDX_W-1:0]     pred_local_idx,
    output logic [bp_pkg::PHT_IDX_W-1:0]     pred_global_idx,
    output logic [bp_pkg::CHOICE_IDX_W-1:0]  pred_choice_idx,
    output logic [bp_pkg::PC_W-1:0]          br_pc_out,
    output logic [bp_pkg::CFG_DATA_W-1:0]    cfg_rdata
);

    bp_pkg::pred_mode_e mode;

    // Component bits go out as prediction info and into the chooser
    local_hist_predictor local_hist_predictor_inst (
        .clk              (clk),
        .rst              (rst),
        .br_pc            (br_pc),
        .commit_update    (commit_update),
        .commit_bht_idx   (commit_bht_idx),
        .commit_local_idx (commit_local_idx),
        .commit_taken     (commit_taken),
        .local_taken      (pred_local_taken),
        .pred_bht_idx     (pred_bht_idx),
        .pred_local_idx   (pred_local_idx),
        .br_pc_out        (br_pc_out)
    );

    gshare_predictor gshare_predictor_inst (
        .clk               (clk),
        .rst               (rst),
        .br_pc             (br_pc),
        .commit_update     (commit_update),
        .commit_global_idx (commit_global_idx),
        .commit_taken      (commit_taken),
        .global_taken      (pred_global_taken),
        .pred_global_idx   (pred_global_idx)
    );

    tournament_chooser tournament_chooser_inst (
        .clk                 (clk),
        .rst                 (rst),
        .br_pc               (br_pc),
        .mode                (mode),
        .local_taken         (pred_local_taken),
        .global_taken        (pred_global_taken),
        .commit_update       (commit_update),
        .commit_choice_idx   (commit_choice_idx),
        .commit_local_taken  (commit_local_taken),
        .commit_global_taken (commit_global_taken),
        .commit_taken        (commit_taken),
        .pred_taken          (pred_taken),
        .pred_choice_idx     (pred_choice_idx)
    );

    predictor_config predictor_config_inst (
        .clk               (clk),
        .rst               (rst),
        .cfg_write         (cfg_write),
        .cfg_addr          (cfg_addr),
        .cfg_wdata         (cfg_wdata),
        .commit_update     (commit_update),
        .commit_pred_taken (commit_pred_taken),
        .commit_taken      (commit_taken),
        .cfg_rdata         (cfg_rdata),
        .mode              (mode)
    );

endmodule

`default_nettype wire

/* predictor_config.sv */
`timescale 1ns/1ps
`default_nettype none

module predictor_config (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             cfg_write,
    input  wire bp_pkg::cfg_reg_e           cfg_addr,
    input  wire [bp_pkg::CFG_DATA_W-1:0]    cfg_wdata,
    input  wire                             commit_update,
    input  wire                             commit_pred_taken,
    input  wire                             commit_taken,
    output logic [bp_pkg::CFG_DATA_W-1:0]   cfg_rdata,
    output bp_pkg::pred_mode_e              mode
);

    logic [bp_pkg::CFG_DATA_W-1:0] commits;
    logic [bp_pkg::CFG_DATA_W-1:0] mispredicts;
    logic                          commits_wrapped;
    logic                          clear;

    assign clear = cfg_write && cfg_addr == bp_pkg::REG_CLEAR;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= bp_pkg::MODE_TOURNAMENT;
        end else if (cfg_write && cfg_addr == bp_pkg::REG_MODE) begin
            mode <= bp_pkg::pred_mode_e'(cfg_wdata[1:0]);
        end
    end

    // Clear wins over a commit in the same cycle
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            commits         <= '0;
            mispredicts     <= '0;
            commits_wrapped <= 1'b0;
        end else if (commit_update) begin
            commits <= commits + 1'b1;
            if (commits == '1) begin
                commits_wrapped <= 1'b1;
            end
            if (commit_pred_taken != commit_taken) begin
                mispredicts <= mispredicts + 1'b1;
            end
        end
    end

    // Combinational read, the clear address reads as zero
    always_comb begin
        case (cfg_addr)
            bp_pkg::REG_MODE:        cfg_rdata = {{(bp_pkg::CFG_DATA_W-2){1'b0}}, mode};
            bp_pkg::REG_COMMITS:     cfg_rdata = commits;
            bp_pkg::REG_MISPREDICTS: cfg_rdata = mispredicts;
            default:                 cfg_rdata = '0;
        endcase
    end

    a_mispredicts_bounded: assert property (
        @(posedge clk) disable iff (rst)
        !commits_wrapped |-> mispredicts <= commits
    ) else $error("mispredicts %0d exceed commits %0d", mispredicts, commits);

endmodule

`default_nettype wire

/* tournament_chooser.sv */
`timescale 1ns/1ps
`default_nettype none

module tournament_chooser (
    input  wire                              clk,
    input  wire                              rst,
    input  wire [bp_pkg::PC_W-1:0]           br_pc,
    input  wire bp_pkg::pred_mode_e          mode,
    input  wire                              local_taken,
    input  wire                              global_taken,
    input  wire                              commit_update,
    input  wire [bp_pkg::CHOICE_IDX_W-1:0]   commit_choice_idx,
    input  wire                              commit_local_taken,
    input  wire                              commit_global_taken,
    input  wire                              commit_taken,
    output logic                             pred_taken,
    output logic [bp_pkg::CHOICE_IDX_W-1:0]  pred_choice_idx
);

    // Upper bit set means trust gshare
    bp_pkg::ctr2_t choice [bp_pkg::CHOICE_ENTRIES];

    bp_pkg::ctr2_t cur_choice;
    logic          disagree;

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_choice_idx <= '0;
        end else begin
            pred_choice_idx <= br_pc[bp_pkg::CHOICE_IDX_W+1:2];
        end
    end

    assign cur_choice = choice[pred_choice_idx];

    // Final selection, mode is applied combinationally
    always_comb begin
        case (mode)
            bp_pkg::MODE_STATIC_NT:  pred_taken = 1'b0;
            bp_pkg::MODE_LOCAL:      pred_taken = local_taken;
            bp_pkg::MODE_GLOBAL:     pred_taken = global_taken;
            bp_pkg::MODE_TOURNAMENT: pred_taken = cur_choice[1] ? global_taken : local_taken;
            default:                 pred_taken = 1'b0;
        endcase
    end

    // Nothing to learn when both predictors said the same thing
    assign disagree = commit_local_taken ^ commit_global_taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::CHOICE_ENTRIES; i++) begin
                choice[i] <= 2'b00;
            end
        end else if (commit_update && disagree) begin
            choice[commit_choice_idx] <= bp_pkg::ctr2_step(
                choice[commit_choice_idx], commit_global_taken == commit_taken);
        end
    end

    // Mode comes from the config block
    a_mode_legal: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(mode) && mode inside {bp_pkg::MODE_STATIC_NT, bp_pkg::MODE_LOCAL,
                                          bp_pkg::MODE_GLOBAL, bp_pkg::MODE_TOURNAMENT}
    ) else $error("illegal prediction mode %0h", mode);

endmodule

`default_nettype wire

/* gshare_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module gshare_predictor (
    input  wire                            clk,
    input  wire                            rst,
    input  wire [bp_pkg::PC_W-1:0]         br_pc,
    input  wire                            commit_update,
    input  wire [bp_pkg::PHT_IDX_W-1:0]    commit_global_idx,
    input  wire                            commit_taken,
    output logic                           global_taken,
    output logic [bp_pkg::PHT_IDX_W-1:0]   pred_global_idx
);

    // Global outcome history, newest outcome in bit 0
    logic [bp_pkg::GHR_LEN-1:0] ghr;

    bp_pkg::ctr2_t pht [bp_pkg::PHT_ENTRIES];

    logic [bp_pkg::PHT_IDX_W-1:0] hash_idx;
    bp_pkg::ctr2_t                cur_ctr;

    assign hash_idx = ghr ^ br_pc[bp_pkg::PHT_IDX_W+1:2];

    // Index register gives the same one-cycle latency as the local side
    always_ff @(posedge clk) begin
        if (rst) begin
            pred_global_idx <= '0;
        end else begin
            pred_global_idx <= hash_idx;
        end
    end

    assign cur_ctr      = pht[pred_global_idx];
    assign global_taken = cur_ctr[1];

    // History only moves at commit
    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
        end else if (commit_update) begin
            ghr <= {ghr[bp_pkg::GHR_LEN-2:0], commit_taken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::PHT_ENTRIES; i++) begin
                pht[i] <= 2'b00;
            end
        end else if (commit_update) begin
            pht[commit_global_idx] <=
                bp_pkg::ctr2_step(pht[commit_global_idx], commit_taken);
        end
    end

    // An unknown outcome would poison both the GHR and the table
    a_commit_taken_known: assert property (
        @(posedge clk) disable iff (rst)
        commit_update |-> !$isunknown(commit_taken)
    ) else $error("commit_taken unknown during commit_update");

endmodule

`default_nettype wire

/* local_hist_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module local_hist_predictor (
    input  wire                            clk,
    input  wire                            rst,
    input  wire [bp_pkg::PC_W-1:0]         br_pc,
    input  wire                            commit_update,
    input  wire [bp_pkg::BHT_IDX_W-1:0]    commit_bht_idx,
    input  wire [bp_pkg::PHT_IDX_W-1:0]    commit_local_idx,
    input  wire                            commit_taken,
    output logic                           local_taken,
    output logic [bp_pkg::BHT_IDX_W-1:0]   pred_bht_idx,
    output logic [bp_pkg::PHT_IDX_W-1:0]   pred_local_idx,
    output logic [bp_pkg::PC_W-1:0]        br_pc_out
);

    // Per-branch history registers and their counters
    logic [bp_pkg::BHR_LEN-1:0] bht [bp_pkg::BHT_ENTRIES];
    bp_pkg::ctr2_t              pht [bp_pkg::PHT_ENTRIES];

    logic [bp_pkg::BHT_IDX_W-1:0] bht_idx;
    logic [bp_pkg::BHR_LEN-1:0]   cur_hist;
    logic [bp_pkg::PHT_IDX_W-1:0] pht_idx;
    bp_pkg::ctr2_t                cur_ctr;

    // Stage 1: history lookup and hash with the PC
    assign bht_idx  = br_pc[bp_pkg::BHT_IDX_W+1:2];
    assign cur_hist = bht[bht_idx];
    assign pht_idx  = cur_hist ^ br_pc[bp_pkg::PHT_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_bht_idx   <= '0;
            pred_local_idx <= '0;
            br_pc_out      <= '0;
        end else begin
            pred_bht_idx   <= bht_idx;
            pred_local_idx <= pht_idx;
            br_pc_out      <= br_pc;
        end
    end

    // Stage 2: counter read from the registered index
    assign cur_ctr     = pht[pred_local_idx];
    assign local_taken = cur_ctr[1];

    // Commit: train the counter and shift the outcome into the history
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::BHT_ENTRIES; i++) begin
                bht[i] <= '0;
            end
            for (int j = 0; j < bp_pkg::PHT_ENTRIES; j++) begin
                pht[j] <= 2'b00;
            end
        end else if (commit_update) begin
            pht[commit_local_idx] <= bp_pkg::ctr2_step(pht[commit_local_idx], commit_taken);
            bht[commit_bht_idx]   <= {bht[commit_bht_idx][bp_pkg::BHR_LEN-2:0], commit_taken};
        end
    end

    // Table contents must stay known once reset has run
    a_local_taken_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(local_taken)
    ) else $error("local_taken is unknown after reset");

endmodule

`default_nettype wire

/* bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // Branch PC
    localparam int PC_W = 32;

    // Local history table, indexed by pc[9:2]
    localparam int BHT_ENTRIES = 256;
    localparam int BHT_IDX_W   = 8;
    localparam int BHR_LEN     = 10;

    // Counter tables of the local and gshare predictors
    localparam int PHT_ENTRIES = 1024;
    localparam int PHT_IDX_W   = 10;

    // Global history length, matches the counter index width
    localparam int GHR_LEN = 10;

    // Chooser table, indexed by pc[9:2]
    localparam int CHOICE_ENTRIES = 256;
    localparam int CHOICE_IDX_W   = 8;

    // Configuration port data width
    localparam int CFG_DATA_W = 32;

    // Two-bit saturating counter, upper bit is taken (or prefer global)
    typedef logic [1:0] ctr2_t;

    typedef enum logic [1:0] {
        MODE_STATIC_NT  = 2'd0,
        MODE_LOCAL      = 2'd1,
        MODE_GLOBAL     = 2'd2,
        MODE_TOURNAMENT = 2'd3
    } pred_mode_e;

    typedef enum logic [1:0] {
        REG_MODE        = 2'd0,
        REG_COMMITS     = 2'd1,
        REG_MISPREDICTS = 2'd2,
        REG_CLEAR       = 2'd3
    } cfg_reg_e;

    // One step toward the outcome, saturating at 00 and 11
    function automatic ctr2_t ctr2_step(input ctr2_t ctr, input logic up);
        ctr2_t next_ctr;
        next_ctr = ctr;
        if (up && ctr != 2'b11) begin
            next_ctr = ctr + 2'b01;
        end else if (!up && ctr != 2'b00) begin
            next_ctr = ctr - 2'b01;
        end
        return next_ctr;
    endfunction

endpackage

`default_nettype wire
